// ==== flow_ctrl_top.f ====
+incdir+logic
logic/flow_pkg.sv
logic/flow_control_fsm.sv
logic/packet_classifier.sv
logic/vc_fifo.sv
logic/vc_dispatcher.sv
logic/flow_ctrl_top.sv
test/flow_ctrl_tb.sv

// ==== logic/flow_consts.svh ====
// Sizing macros for the virtual-channel FIFOs, included by any file that sizes a buffer
`ifndef FLOW_CONSTS_SVH
`define FLOW_CONSTS_SVH

// Entries per channel FIFO
`define FLOW_FIFO_DEPTH 8

// Read and write pointer width, wraps naturally at the depth
`define FLOW_PTR_W 3

// Stored-word count, one bit wider than the pointers to reach full
`define FLOW_CNT_W 4

`endif

// ==== logic/flow_control_fsm.sv ====
// Control state machine of the flow stage, sequences init, idle, active and error
module flow_control_fsm (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     init,
  input  flow_pkg::threshold_cfg_t threshold_cfg,
  input  flow_pkg::fifo_flags_t    vc0_flags,
  input  flow_pkg::fifo_flags_t    vc1_flags,
  output flow_pkg::threshold_cfg_t thresholds,
  output logic                     enable,
  output logic                     run,
  output flow_pkg::fsm_status_t    status
);

  // One-hot state encoding
  localparam logic [4:0] st_reset  = 5'b00001;
  localparam logic [4:0] st_init   = 5'b00010;
  localparam logic [4:0] st_idle   = 5'b00100;
  localparam logic [4:0] st_active = 5'b01000;
  localparam logic [4:0] st_error  = 5'b10000;

  logic [4:0] state;
  logic [4:0] state_next;
  logic       any_overflow;
  logic       both_empty;

  assign any_overflow = vc0_flags.overflow | vc1_flags.overflow;
  assign both_empty   = vc0_flags.empty & vc1_flags.empty;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_reset;
    end else begin
      state <= state_next;
    end
  end

  // Threshold word taken with the init pulse, held from the init state on
  always_ff @(posedge clk) begin
    if (reset) begin
      thresholds <= '0;
    end else if (state == st_reset && init) begin
      thresholds <= threshold_cfg;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      st_reset: begin
        if (init) begin
          state_next = st_init;
        end
      end
      st_init: begin
        state_next = st_idle;
      end
      st_idle: begin
        if (!both_empty) begin
          state_next = st_active;
        end
      end
      st_active: begin
        if (both_empty) begin
          state_next = st_idle;
        end
      end
      // Left only by reset
      st_error: begin
        state_next = st_error;
      end
      default: begin
        state_next = st_reset;
      end
    endcase
    // Overflow anywhere wins over the normal flow
    if (any_overflow) begin
      state_next = st_error;
    end
  end

  // Outputs decode the registered state
  assign status.idle   = (state == st_idle);
  assign status.active = (state == st_active);
  assign status.error  = (state == st_error);
  assign enable        = (state == st_idle) | (state == st_active);
  assign run           = (state == st_active);

  a_state_onehot: assert property (@(posedge clk) disable iff (reset) $onehot(state))
    else $error("controller state is not one-hot");

endmodule

// ==== logic/flow_ctrl_top.sv ====
// Top of the two-channel flow stage, joins controller, classifier, channel FIFOs and dispatcher
module flow_ctrl_top (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     init,
  input  flow_pkg::threshold_cfg_t threshold_cfg,
  input  logic                     in_valid,
  input  flow_pkg::packet_t        in_word,
  input  logic                     out_pause,
  output logic                     out_valid,
  output flow_pkg::packet_t        out_word,
  output flow_pkg::fsm_status_t    status,
  output flow_pkg::fifo_flags_t    vc0_flags,
  output flow_pkg::fifo_flags_t    vc1_flags
);

  flow_pkg::threshold_cfg_t thresholds;
  flow_pkg::packet_t        push_word;
  flow_pkg::packet_t        vc0_head;
  flow_pkg::packet_t        vc1_head;
  logic                     enable;
  logic                     run;
  logic                     push_vc0;
  logic                     push_vc1;
  logic                     pop_vc0;
  logic                     pop_vc1;

  flow_control_fsm u_flow_control_fsm (
    .clk           (clk),
    .reset         (reset),
    .init          (init),
    .threshold_cfg (threshold_cfg),
    .vc0_flags     (vc0_flags),
    .vc1_flags     (vc1_flags),
    .thresholds    (thresholds),
    .enable        (enable),
    .run           (run),
    .status        (status)
  );

  packet_classifier u_packet_classifier (
    .clk       (clk),
    .reset     (reset),
    .enable    (enable),
    .in_valid  (in_valid),
    .in_word   (in_word),
    .push_vc0  (push_vc0),
    .push_vc1  (push_vc1),
    .push_word (push_word)
  );

  // Both channels share the classifier word bus
  vc_fifo u_vc0_fifo (
    .clk        (clk),
    .reset      (reset),
    .push       (push_vc0),
    .push_word  (push_word),
    .pop        (pop_vc0),
    .thresholds (thresholds),
    .head       (vc0_head),
    .flags      (vc0_flags)
  );

  vc_fifo u_vc1_fifo (
    .clk        (clk),
    .reset      (reset),
    .push       (push_vc1),
    .push_word  (push_word),
    .pop        (pop_vc1),
    .thresholds (thresholds),
    .head       (vc1_head),
    .flags      (vc1_flags)
  );

  vc_dispatcher u_vc_dispatcher (
    .clk       (clk),
    .reset     (reset),
    .run       (run),
    .out_pause (out_pause),
    .vc0_head  (vc0_head),
    .vc1_head  (vc1_head),
    .vc0_empty (vc0_flags.empty),
    .vc1_empty (vc1_flags.empty),
    .pop_vc0   (pop_vc0),
    .pop_vc1   (pop_vc1),
    .out_valid (out_valid),
    .out_word  (out_word)
  );

endmodule

// ==== logic/flow_pkg.sv ====
// Shared types for the two-channel flow-control stage, used by RTL and testbench by scoped name
package flow_pkg;

  // One link word, the channel bit steers it to a FIFO
  typedef struct packed {
    logic       vc_id;
    logic [6:0] data;
  } packet_t;

  // Threshold word from the host
  // The controller captures it whole, each FIFO reads the two levels
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      // Almost-full when count reaches this level
      logic [3:0] af_level;
      // Almost-empty while count is at or below this level
      logic [3:0] ae_level;
    } fields;
  } threshold_cfg_t;

  // Per-channel buffer levels
  typedef struct packed {
    logic empty;
    logic full;
    logic almost_full;
    logic almost_empty;
    // sticky until reset
    logic overflow;
  } fifo_flags_t;

  // Controller levels, at most one is high
  typedef struct packed {
    logic idle;
    logic active;
    logic error;
  } fsm_status_t;

endpackage

// ==== logic/packet_classifier.sv ====
// Producer side of the flow stage, registers input words and steers them to a channel FIFO
module packet_classifier (
  input  logic              clk,
  input  logic              reset,
  input  logic              enable,
  input  logic              in_valid,
  input  flow_pkg::packet_t in_word,
  output logic              push_vc0,
  output logic              push_vc1,
  output flow_pkg::packet_t push_word
);

  logic accept;

  // Words seen while disabled are dropped here
  assign accept = enable & in_valid;

  // Push strobes, one cycle after the input strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      push_vc0 <= 1'b0;
      push_vc1 <= 1'b0;
    end else begin
      push_vc0 <= accept & ~in_word.vc_id;
      push_vc1 <= accept & in_word.vc_id;
    end
  end

  // Payload register, only loaded on an accepted word
  always_ff @(posedge clk) begin
    if (accept) begin
      push_word <= in_word;
    end
  end

  a_push_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(push_vc0 && push_vc1))
    else $error("both channel pushes raised in one cycle");

endmodule

// ==== logic/vc_dispatcher.sv ====
// Consumer side of the flow stage, drains the two channels by fixed priority to the output
module vc_dispatcher (
  input  logic              clk,
  input  logic              reset,
  input  logic              run,
  input  logic              out_pause,
  input  flow_pkg::packet_t vc0_head,
  input  flow_pkg::packet_t vc1_head,
  input  logic              vc0_empty,
  input  logic              vc1_empty,
  output logic              pop_vc0,
  output logic              pop_vc1,
  output logic              out_valid,
  output flow_pkg::packet_t out_word
);

  logic can_pop;

  // No pop outside active or under back-pressure
  assign can_pop = run & ~out_pause;

  // Channel 0 always goes first
  assign pop_vc0 = can_pop & ~vc0_empty;
  assign pop_vc1 = can_pop & vc0_empty & ~vc1_empty;

  // Output strobe, one cycle after the pop
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= pop_vc0 | pop_vc1;
    end
  end

  // Popped word is held until the next pop
  always_ff @(posedge clk) begin
    if (pop_vc0) begin
      out_word <= vc0_head;
    end else if (pop_vc1) begin
      out_word <= vc1_head;
    end
  end

  a_pop_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(pop_vc0 && pop_vc1))
    else $error("both channels popped in one cycle");

endmodule

// ==== logic/vc_fifo.sv ====
// Circular buffer with show-ahead head, count flags and sticky overflow that the top uses per channel
`include "flow_consts.svh"

module vc_fifo (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     push,
  input  flow_pkg::packet_t        push_word,
  input  logic                     pop,
  input  flow_pkg::threshold_cfg_t thresholds,
  output flow_pkg::packet_t        head,
  output flow_pkg::fifo_flags_t    flags
);

  localparam logic [`FLOW_CNT_W-1:0] fifo_depth = `FLOW_FIFO_DEPTH;

  flow_pkg::packet_t mem [0:`FLOW_FIFO_DEPTH-1];

  logic [`FLOW_PTR_W-1:0] wr_ptr;
  logic [`FLOW_PTR_W-1:0] rd_ptr;
  logic [`FLOW_CNT_W-1:0] count;
  logic                   overflow;
  logic                   is_empty;
  logic                   is_full;
  logic                   do_push;

  assign is_empty = (count == '0);
  assign is_full  = (count == fifo_depth);

  // A full buffer refuses the push even if a pop happens in the same cycle
  assign do_push = push & ~is_full;

  // Storage written at the tail
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_word;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else begin
      case ({do_push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Dropped word leaves a mark until reset
  always_ff @(posedge clk) begin
    if (reset) begin
      overflow <= 1'b0;
    end else if (push && is_full) begin
      overflow <= 1'b1;
    end
  end

  // Show-ahead head is valid whenever the buffer is not empty
  assign head = mem[rd_ptr];

  // Levels come from the fields view of the threshold word
  assign flags.empty        = is_empty;
  assign flags.full         = is_full;
  assign flags.almost_full  = (count >= thresholds.fields.af_level);
  assign flags.almost_empty = (count <= thresholds.fields.ae_level);
  assign flags.overflow     = overflow;

  // the dispatcher is expected to gate its pops on the empty flag
  a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
    pop |-> !is_empty)
    else $error("pop issued to an empty channel FIFO");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the flow stage testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f flow_ctrl_top.f \
  --top-module flow_ctrl_tb \
  -o flow_ctrl_sim

# The log decides the result, the simulator status may vary on assertion stops
./obj_dir/flow_ctrl_sim > sim.log 2>&1 || true
cat sim.log

if grep -qxF '** PASS **' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== test/flow_ctrl_tb.sv ====
// Self-checking testbench for the two-channel flow stage, run as the simulation top with the RTL
`include "flow_consts.svh"

module flow_ctrl_tb;

  localparam int cycle_limit = 2000;
  localparam int random_cycles = 300;

  logic                     clk;
  logic                     reset;
  logic                     init;
  flow_pkg::threshold_cfg_t threshold_cfg;
  logic                     in_valid;
  flow_pkg::packet_t        in_word;
  logic                     out_pause;
  logic                     out_valid;
  flow_pkg::packet_t        out_word;
  flow_pkg::fsm_status_t    status;
  flow_pkg::fifo_flags_t    vc0_flags;
  flow_pkg::fifo_flags_t    vc1_flags;

  // Reference model state
  flow_pkg::packet_t        q0[$];
  flow_pkg::packet_t        q1[$];
  flow_pkg::threshold_cfg_t ref_thr;
  logic                     ref_ovf0;
  logic                     ref_ovf1;
  logic                     ref_inited;
  logic                     ref_err;
  logic                     ref_enabled;
  logic                     strict_priority;
  logic                     no_output_expected;

  string       test_name;
  int          error_count;
  int          errors_at_start;
  int          tests_run;
  int          tests_failed;
  int          sent_total;
  int          recv_total;
  int          cycle_count;
  logic [31:0] lcg_state;

  flow_ctrl_top u_flow_ctrl_top (
    .clk           (clk),
    .reset         (reset),
    .init          (init),
    .threshold_cfg (threshold_cfg),
    .in_valid      (in_valid),
    .in_word       (in_word),
    .out_pause     (out_pause),
    .out_valid     (out_valid),
    .out_word      (out_word),
    .status        (status),
    .vc0_flags     (vc0_flags),
    .vc1_flags     (vc1_flags)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Expected flags from a word count and the latched threshold fields
  function automatic flow_pkg::fifo_flags_t ref_flags(input int count, input logic ovf);
    flow_pkg::fifo_flags_t f;
    f.empty        = (count == 0);
    f.full         = (count == `FLOW_FIFO_DEPTH);
    f.almost_full  = (count >= int'(ref_thr.fields.af_level));
    f.almost_empty = (count <= int'(ref_thr.fields.ae_level));
    f.overflow     = ovf;
    return f;
  endfunction

  // Controller rule, valid once the stage has settled
  function automatic flow_pkg::fsm_status_t ref_status();
    flow_pkg::fsm_status_t s;
    s = '0;
    if (ref_inited && ref_err) begin
      s.error = 1'b1;
    end else if (ref_inited && (q0.size() + q1.size() != 0)) begin
      s.active = 1'b1;
    end else if (ref_inited) begin
      s.idle = 1'b1;
    end
    return s;
  endfunction

  // Next expected output word; channel 0 first when priority is strictly predictable
  function automatic bit ref_next_out(input logic got_vc, output flow_pkg::packet_t exp);
    logic ch;
    ch = got_vc;
    if (strict_priority) begin
      ch = (q0.size() != 0) ? 1'b0 : 1'b1;
    end
    if (ch == 1'b0) begin
      if (q0.size() == 0) return 1'b0;
      exp = q0.pop_front();
    end else begin
      if (q1.size() == 0) return 1'b0;
      exp = q1.pop_front();
    end
    return 1'b1;
  endfunction

  // A word accepted by the stage lands in its channel unless that channel is full
  function automatic void ref_accept(input flow_pkg::packet_t w);
    if (!ref_enabled) return;
    sent_total++;
    if (w.vc_id == 1'b0 && q0.size() == `FLOW_FIFO_DEPTH) begin
      ref_ovf0    = 1'b1;
      ref_err     = 1'b1;
      ref_enabled = 1'b0;
    end else if (w.vc_id == 1'b1 && q1.size() == `FLOW_FIFO_DEPTH) begin
      ref_ovf1    = 1'b1;
      ref_err     = 1'b1;
      ref_enabled = 1'b0;
    end else if (w.vc_id == 1'b0) begin
      q0.push_back(w);
    end else begin
      q1.push_back(w);
    end
  endfunction

  task automatic report_error(input string msg);
    $display("test %s: %s", test_name, msg);
    error_count++;
  endtask

  task automatic check_packet(input string what, input flow_pkg::packet_t exp,
                              input flow_pkg::packet_t act);
    if (act !== exp) begin
      $display("ERR %s %s: expected %h actual %h", test_name, what, exp, act);
      error_count++;
    end
  endtask

  task automatic check_flags(input string what, input flow_pkg::fifo_flags_t exp,
                             input flow_pkg::fifo_flags_t act);
    if (act !== exp) begin
      $display("ERR %s %s: expected %b actual %b", test_name, what, exp, act);
      error_count++;
    end
  endtask

  task automatic check_status(input string what, input flow_pkg::fsm_status_t exp,
                              input flow_pkg::fsm_status_t act);
    if (act !== exp) begin
      $display("ERR %s %s: expected %b actual %b", test_name, what, exp, act);
      error_count++;
    end
  endtask

  task automatic check_levels();
    check_flags("vc0_flags", ref_flags(q0.size(), ref_ovf0), vc0_flags);
    check_flags("vc1_flags", ref_flags(q1.size(), ref_ovf1), vc1_flags);
    check_status("status", ref_status(), status);
  endtask

  // Output compare process, outputs are stable at the falling edge
  always @(negedge clk) begin
    flow_pkg::packet_t exp;
    if (!reset && out_valid) begin
      recv_total++;
      if (no_output_expected) begin
        report_error("output word appeared while the stage is in error");
      end else if (!ref_next_out(out_word.vc_id, exp)) begin
        report_error("output word appeared with no word expected on its channel");
      end else begin
        check_packet("out_word", exp, out_word);
      end
    end
  end

  // Cycle limit covers all tests with margin
  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    $display("** FAIL **");
    $finish;
  end

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = error_count;
    sent_total      = 0;
    recv_total      = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    if (error_count != errors_at_start) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name, error_count - errors_at_start);
    end else begin
      $display("test %s: ok", test_name);
    end
  endtask

  // One word, one strobe cycle, then a gap
  task automatic send_word(input logic vc, input logic [6:0] data);
    flow_pkg::packet_t w;
    w.vc_id = vc;
    w.data  = data;
    @(posedge clk);
    in_valid <= 1'b1;
    in_word  <= w;
    ref_accept(w);
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic settle(input int n);
    repeat (n) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic wait_drain();
    while (q0.size() != 0 || q1.size() != 0) @(posedge clk);
    settle(3);
  endtask

  task automatic reset_stage();
    @(posedge clk);
    reset    <= 1'b1;
    init     <= 1'b0;
    in_valid <= 1'b0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    q0.delete();
    q1.delete();
    ref_thr            = '0;
    ref_ovf0           = 1'b0;
    ref_ovf1           = 1'b0;
    ref_inited         = 1'b0;
    ref_err            = 1'b0;
    ref_enabled        = 1'b0;
    no_output_expected = 1'b0;
    @(negedge clk);
  endtask

  // Init pulse, the stage is idle two edges after the pulse is seen
  task automatic init_stage(input logic [7:0] cfg);
    @(posedge clk);
    init              <= 1'b1;
    threshold_cfg.raw <= cfg;
    @(posedge clk);
    init <= 1'b0;
    settle(1);
    ref_thr.raw = cfg;
    ref_inited  = 1'b1;
    ref_enabled = 1'b1;
    check_status("status after init", ref_status(), status);
  endtask

  task automatic random_traffic();
    logic [31:0]       r;
    flow_pkg::packet_t w;
    int                depth_used;
    for (int i = 0; i < random_cycles; i++) begin
      r = lcg_next();
      w.vc_id = r[21];
      w.data  = r[28:22];
      depth_used = w.vc_id ? q1.size() : q0.size();
      @(posedge clk);
      out_pause <= (r[17:16] == 2'b00);
      if (r[18] && depth_used < `FLOW_FIFO_DEPTH) begin
        in_valid <= 1'b1;
        in_word  <= w;
        ref_accept(w);
      end else begin
        in_valid <= 1'b0;
      end
    end
    @(posedge clk);
    in_valid  <= 1'b0;
    out_pause <= 1'b0;
  endtask

  initial begin
    reset              = 1'b1;
    init               = 1'b0;
    threshold_cfg      = '0;
    in_valid           = 1'b0;
    in_word            = '0;
    out_pause          = 1'b0;
    lcg_state          = 32'd20141;
    strict_priority    = 1'b0;
    error_count        = 0;
    tests_run          = 0;
    tests_failed       = 0;
    reset_stage();

    start_test("pre_init");
    check_status("status", ref_status(), status);
    send_word(1'b0, 7'h11);
    send_word(1'b1, 7'h22);
    send_word(1'b0, 7'h33);
    settle(3);
    check_levels();
    finish_test();

    start_test("thresholds");
    @(posedge clk);
    out_pause <= 1'b1;
    init_stage(8'h62);
    // A new word on the input must not reach the FIFOs
    @(posedge clk);
    threshold_cfg.raw <= 8'h1f;
    for (int i = 0; i < 6; i++) begin
      send_word(1'b0, 7'(8'h10 + i));
      settle(1);
      check_flags("vc0_flags", ref_flags(q0.size(), ref_ovf0), vc0_flags);
    end
    settle(1);
    check_levels();
    @(posedge clk);
    out_pause <= 1'b0;
    wait_drain();
    check_levels();
    finish_test();

    start_test("priority");
    strict_priority = 1'b1;
    @(posedge clk);
    out_pause <= 1'b1;
    for (int i = 0; i < 10; i++) begin
      send_word(~i[0], 7'(8'h40 + i));
    end
    settle(2);
    check_levels();
    @(posedge clk);
    out_pause <= 1'b0;
    wait_drain();
    check_levels();
    strict_priority = 1'b0;
    finish_test();

    start_test("overflow");
    @(posedge clk);
    out_pause <= 1'b1;
    for (int i = 0; i < 9; i++) begin
      send_word(1'b1, 7'(8'h60 + i));
    end
    settle(2);
    check_levels();
    no_output_expected = 1'b1;
    @(posedge clk);
    out_pause <= 1'b0;
    settle(20);
    check_levels();
    reset_stage();
    check_levels();
    finish_test();

    start_test("random");
    init_stage(8'h53);
    random_traffic();
    wait_drain();
    check_levels();
    if (recv_total != sent_total) begin
      $display("ERR %s totals: expected %0d actual %0d", test_name, sent_total, recv_total);
      error_count++;
    end
    finish_test();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
